// File: ncpu_irq_pkg.sv
// Timer and interrupt register block, shared definitions
// Data and address widths, TCR field layout and the APB register map
package ncpu_irq_pkg;

   localparam int msr_dw = 32;   // Register data width
   localparam int msr_aw = 4;    // APB address width

   // Register offsets seen on the APB side
   typedef enum logic [msr_aw-1:0]
   {
      msr_tsr = 4'h0,            // Timestamp counter
      msr_tcr = 4'h4,            // Timer control
      msr_imr = 4'h8,            // Interrupt mask
      msr_irr = 4'hc             // Interrupt request, read only
   } msr_addr_e;

   // TCR field positions
   localparam int tcr_en_bit = 31;   // Counter enable
   localparam int tcr_ie_bit = 30;   // Interrupt enable
   localparam int tcr_p_bit  = 29;   // Pending flag

   // Compare count held in TCR[27:0]
   localparam int tcr_cnt_w = 28;

endpackage

// File: msr_apb_slave.sv
// APB register front end for the timer and interrupt block
// Decodes the access phase into write strobes and muxes read data
// Flags unmapped offsets and writes to IRR with pslverr
`timescale 1ns/1ps

module msr_apb_slave
(
   input  logic                              clk,
   input  logic                              rst_n,
   // APB slave side
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [ncpu_irq_pkg::msr_aw-1:0]   paddr,
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   pwdata,
   output logic [ncpu_irq_pkg::msr_dw-1:0]   prdata,
   output logic                              pready,
   output logic                              pslverr,
   // Register write strobes
   output logic                              tsr_we,
   output logic                              tcr_we,
   output logic                              imr_we,
   output logic [ncpu_irq_pkg::msr_dw-1:0]   wdata,
   // Register read values
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   tsr,
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   tcr,
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   imr,
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   irr
);

   ncpu_irq_pkg::msr_addr_e               addr;
   logic                                  setup_q;
   logic                                  access;
   logic                                  addr_ok;
   logic                                  irr_wr;
   logic [ncpu_irq_pkg::msr_dw-1:0]       rd_mux;

   assign addr = ncpu_irq_pkg::msr_addr_e'(paddr);

   // Remembers that the previous cycle was a setup phase
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         setup_q <= 1'b0;
      else
         setup_q <= psel & ~penable;
   end

   assign access = psel & penable & setup_q;   // Access phase following setup

   // Address decode and read mux
   always_comb
   begin
      addr_ok = 1'b1;
      rd_mux  = '0;
      case (addr)
         ncpu_irq_pkg::msr_tsr: rd_mux = tsr;
         ncpu_irq_pkg::msr_tcr: rd_mux = tcr;
         ncpu_irq_pkg::msr_imr: rd_mux = imr;
         ncpu_irq_pkg::msr_irr: rd_mux = irr;
         default:               addr_ok = 1'b0;   // Unmapped offset
      endcase
   end

   assign irr_wr  = pwrite & (addr == ncpu_irq_pkg::msr_irr);
   assign pslverr = access & (~addr_ok | irr_wr);

   // One-cycle strobes, taken on the access edge
   assign tsr_we = access & pwrite & (addr == ncpu_irq_pkg::msr_tsr);
   assign tcr_we = access & pwrite & (addr == ncpu_irq_pkg::msr_tcr);
   assign imr_we = access & pwrite & (addr == ncpu_irq_pkg::msr_imr);
   assign wdata  = pwdata;

   // Zero outside a good read access
   assign prdata = (access & ~pwrite & addr_ok) ? rd_mux : '0;
   assign pready = 1'b1;   // No wait states

endmodule

// File: ncpu_tsc.sv
// Timestamp counter
// Free-running TSR with a 28-bit compare against the TCR count field
// Sets a sticky pending flag and raises tsc_irq when interrupts are enabled
`timescale 1ns/1ps

module ncpu_tsc
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              tsr_we,
   input  logic                              tcr_we,
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   wdata,
   output logic [ncpu_irq_pkg::msr_dw-1:0]   tsr,
   output logic [ncpu_irq_pkg::msr_dw-1:0]   tcr,
   output logic                              tsc_irq
);

   logic                                     tcr_en;
   logic                                     tcr_ie;
   logic                                     tcr_p;
   logic [ncpu_irq_pkg::tcr_cnt_w-1:0]       tcr_cnt;
   logic                                     cmp_hit;

   assign cmp_hit = tcr_en & (tsr[ncpu_irq_pkg::tcr_cnt_w-1:0] == tcr_cnt);

   // Counter, a write replaces the increment
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         tsr <= '0;
      else if (tsr_we)
         tsr <= wdata;
      else if (tcr_en)
         tsr <= tsr + 1;
   end

   // Control fields and sticky pending flag
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tcr_en  <= 1'b0;
         tcr_ie  <= 1'b0;
         tcr_p   <= 1'b0;
         tcr_cnt <= '0;
      end
      else if (tcr_we)
      begin
         tcr_en  <= wdata[ncpu_irq_pkg::tcr_en_bit];
         tcr_ie  <= wdata[ncpu_irq_pkg::tcr_ie_bit];
         tcr_p   <= wdata[ncpu_irq_pkg::tcr_p_bit];   // Writing 0 clears P
         tcr_cnt <= wdata[ncpu_irq_pkg::tcr_cnt_w-1:0];
      end
      else if (cmp_hit)
         tcr_p <= 1'b1;
   end

   // Readback view, bit 28 reads zero
   always_comb
   begin
      tcr = '0;
      tcr[ncpu_irq_pkg::tcr_en_bit]      = tcr_en;
      tcr[ncpu_irq_pkg::tcr_ie_bit]      = tcr_ie;
      tcr[ncpu_irq_pkg::tcr_p_bit]       = tcr_p;
      tcr[ncpu_irq_pkg::tcr_cnt_w-1:0]   = tcr_cnt;
   end

   assign tsc_irq = tcr_p & tcr_ie;

endmodule

// File: ncpu_irqc.sv
// Interrupt controller
// Synchronizes the level IRQ lines, merges the timer interrupt onto its line
// and raises a registered request for any pending line not masked in IMR
`timescale 1ns/1ps

module ncpu_irqc
#(
   parameter int nirq           = 32,
   parameter int irq_lineno_tsc = 0
)
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [nirq-1:0]                   irqs,
   input  logic                              tsc_irq,
   input  logic                              imr_we,
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   wdata,
   output logic [ncpu_irq_pkg::msr_dw-1:0]   imr,
   output logic [nirq-1:0]                   irr,
   output logic                              intr
);

   logic [nirq-1:0]                          irq_sync1;
   logic [nirq-1:0]                          irq_sync2;
   logic [nirq-1:0]                          irq_lvl;

   // Two-flop synchronizer on the asynchronous lines
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         irq_sync1 <= '0;
         irq_sync2 <= '0;
      end
      else
      begin
         irq_sync1 <= irqs;
         irq_sync2 <= irq_sync1;
      end
   end

   // Timer interrupt shares one line with the external source
   always_comb
   begin
      irq_lvl                 = irq_sync2;
      irq_lvl[irq_lineno_tsc] = irq_sync2[irq_lineno_tsc] | tsc_irq;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         irr  <= '0;
         imr  <= '0;
         intr <= 1'b0;
      end
      else
      begin
         irr  <= irq_lvl;                      // Follows the level, not latched
         intr <= |(irr & ~imr[nirq-1:0]);      // Mask bit 1 blocks the line
         if (imr_we)
            imr <= wdata;
      end
   end

endmodule

// File: ncpu_irq_top.sv
// Timer and interrupt block, top level
// APB register front end feeding the timestamp counter and the
// interrupt controller, with the timer interrupt on a chosen IRQ line
`timescale 1ns/1ps

module ncpu_irq_top
#(
   parameter int nirq           = 32,   // At most msr_dw lines
   parameter int irq_lineno_tsc = 0     // Line carrying the timer interrupt
)
(
   input  logic                              clk,
   input  logic                              rst_n,
   // APB
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [ncpu_irq_pkg::msr_aw-1:0]   paddr,
   input  logic [ncpu_irq_pkg::msr_dw-1:0]   pwdata,
   output logic [ncpu_irq_pkg::msr_dw-1:0]   prdata,
   output logic                              pready,
   output logic                              pslverr,
   // Interrupts
   input  logic [nirq-1:0]                   irqs,
   output logic                              intr
);

   logic                                     tsr_we;
   logic                                     tcr_we;
   logic                                     imr_we;
   logic [ncpu_irq_pkg::msr_dw-1:0]          wdata;
   logic [ncpu_irq_pkg::msr_dw-1:0]          tsr;
   logic [ncpu_irq_pkg::msr_dw-1:0]          tcr;
   logic [ncpu_irq_pkg::msr_dw-1:0]          imr;
   logic [nirq-1:0]                          irr;
   logic [ncpu_irq_pkg::msr_dw-1:0]          irr_ext;
   logic                                     tsc_irq;

   // IRR padded to the register width
   always_comb
   begin
      irr_ext           = '0;
      irr_ext[nirq-1:0] = irr;
   end

   msr_apb_slave u_apb
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .imr_we  (imr_we),
      .wdata   (wdata),
      .tsr     (tsr),
      .tcr     (tcr),
      .imr     (imr),
      .irr     (irr_ext)
   );

   ncpu_tsc u_tsc
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .wdata   (wdata),
      .tsr     (tsr),
      .tcr     (tcr),
      .tsc_irq (tsc_irq)
   );

   ncpu_irqc
   #(
      .nirq           (nirq),
      .irq_lineno_tsc (irq_lineno_tsc)
   )
   u_irqc
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .irqs    (irqs),
      .tsc_irq (tsc_irq),
      .imr_we  (imr_we),
      .wdata   (wdata),
      .imr     (imr),
      .irr     (irr),
      .intr    (intr)
   );

endmodule

// File: tb_ncpu_irq.sv
// Testbench for the timer and interrupt block
// Random APB traffic and IRQ patterns checked against a register model
`timescale 1ns/1ps

module tb_ncpu_irq;

   localparam int cycle_limit = 4000;   // ~300 transfers of 2 cycles plus waits, doubled

   logic                              clk = 1'b0;
   logic                              rst_n;
   logic                              psel;
   logic                              penable;
   logic                              pwrite;
   logic [ncpu_irq_pkg::msr_aw-1:0]   paddr;
   logic [ncpu_irq_pkg::msr_dw-1:0]   pwdata;
   logic [ncpu_irq_pkg::msr_dw-1:0]   prdata;
   logic                              pready;
   logic                              pslverr;
   logic [31:0]                       irqs;
   logic                              intr;

   int                                cycles = 0;
   int                                acc_cycle;    // Cycle of the last access phase
   int                                test_errs = 0;
   int                                pass_cnt = 0;
   int                                fail_cnt = 0;
   logic [31:0]                       model_imr;
   logic [31:0]                       model_tcr;

   ncpu_irq_top UUT
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irqs    (irqs),
      .intr    (intr)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit)
      begin
         $display("Run stopped: cycle limit of %0d reached", cycle_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   // Setup then access phase, sampled before the access edge
   task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #1;
      penable = 1'b1;
      #3;
      rdata     = prdata;
      err       = pslverr;
      acc_cycle = cycles;
   endtask

   task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
      logic [31:0] unused_rd;
      apb_xfer(1'b1, addr, data, unused_rd, err);
   endtask

   task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
      apb_xfer(1'b0, addr, '0, rdata, err);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
         psel    = 1'b0;
         penable = 1'b0;
         pwrite  = 1'b0;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp)
      else
      begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         test_errs++;
      end
   endtask

   task automatic end_test(input string name);
      if (test_errs == 0)
      begin
         pass_cnt++;
         $display("Test %-12s passed", name);
      end
      else
      begin
         fail_cnt++;
         $display("Test %-12s failed with %0d errors", name, test_errs);
      end
      test_errs = 0;
   endtask

   initial
   begin : main_seq
      logic [31:0] wd;
      logic [31:0] rd;
      logic [31:0] rd2;
      logic [3:0]  bad;
      logic        err;
      int          t1;
      int          n;
      int          tries;

      rst_n     = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      irqs      = '0;
      model_imr = '0;
      model_tcr = '0;
      void'($urandom(89));
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;

      for (int i = 0; i < 16; i++)
      begin
         wd = $urandom();
         apb_write(ncpu_irq_pkg::msr_imr, wd, err);
         model_imr = wd;
         apb_read(ncpu_irq_pkg::msr_imr, rd, err);
         check_value("readback IMR", model_imr, rd);
         wd     = $urandom();
         wd[31] = 1'b0;                                // Counter stays stopped
         apb_write(ncpu_irq_pkg::msr_tcr, wd, err);
         model_tcr = {wd[31:29], 1'b0, wd[27:0]};      // Bit 28 holds no field
         apb_read(ncpu_irq_pkg::msr_tcr, rd, err);
         check_value("readback TCR", model_tcr, rd);
         wd = $urandom();
         apb_write(ncpu_irq_pkg::msr_tsr, wd, err);
         apb_read(ncpu_irq_pkg::msr_tsr, rd, err);
         check_value("readback TSR", wd, rd);
         check_value("readback pslverr", 32'd0, {31'b0, err});
         check_value("readback pready", 32'd1, {31'b0, pready});
      end
      end_test("reg_readback");

      for (int i = 0; i < 12; i++)
      begin
         wd  = $urandom();
         bad = wd[3:0];
         if (bad[1:0] == 2'b00)
            bad[0] = 1'b1;                             // Off the word grid
         apb_xfer(wd[4], bad, $urandom(), rd, err);
         check_value("errors bad addr pslverr", 32'd1, {31'b0, err});
         check_value("errors bad addr rdata", 32'd0, rd);
         apb_write(ncpu_irq_pkg::msr_irr, $urandom(), err);
         check_value("errors IRR write pslverr", 32'd1, {31'b0, err});
         apb_read(ncpu_irq_pkg::msr_imr, rd, err);
         check_value("errors IMR kept", model_imr, rd);
         apb_read(ncpu_irq_pkg::msr_tcr, rd, err);
         check_value("errors TCR kept", model_tcr, rd);
      end
      end_test("errors");

      apb_write(ncpu_irq_pkg::msr_tsr, $urandom(), err);
      wd     = $urandom();
      wd[31] = 1'b1;
      wd[30] = 1'b0;                                   // Count without interrupt
      apb_write(ncpu_irq_pkg::msr_tcr, wd, err);
      for (int i = 0; i < 8; i++)
      begin
         apb_read(ncpu_irq_pkg::msr_tsr, rd, err);
         t1 = acc_cycle;
         idle_cycles($urandom_range(12, 0));
         apb_read(ncpu_irq_pkg::msr_tsr, rd2, err);
         check_value("counting delta", acc_cycle - t1, rd2 - rd);
      end
      apb_write(ncpu_irq_pkg::msr_tcr, '0, err);
      model_tcr = '0;
      end_test("counting");

      for (int i = 0; i < 12; i++)
      begin
         model_imr = $urandom();
         apb_write(ncpu_irq_pkg::msr_imr, model_imr, err);
         idle_cycles(1);
         wd   = $urandom();
         irqs = wd;
         idle_cycles(5 + $urandom_range(3, 0));
         apb_read(ncpu_irq_pkg::msr_irr, rd, err);
         check_value("ext_irq IRR", wd, rd);
         check_value("ext_irq intr", {31'b0, |(wd & ~model_imr)}, {31'b0, intr});
      end
      idle_cycles(1);
      irqs = '0;
      end_test("ext_irq");

      idle_cycles(4);                                  // Cleared lines pass the synchronizer
      for (int i = 0; i < 4; i++)
      begin
         model_imr = $urandom();
         apb_write(ncpu_irq_pkg::msr_imr, model_imr, err);
         apb_write(ncpu_irq_pkg::msr_tsr, '0, err);
         n        = $urandom_range(15, 1);
         wd       = '0;
         wd[ncpu_irq_pkg::tcr_en_bit] = 1'b1;
         wd[ncpu_irq_pkg::tcr_ie_bit] = 1'b1;
         wd[27:0] = n[27:0];
         apb_write(ncpu_irq_pkg::msr_tcr, wd, err);
         idle_cycles(n + 7);
         wd[ncpu_irq_pkg::tcr_p_bit] = 1'b1;           // Compare has fired
         apb_read(ncpu_irq_pkg::msr_tcr, rd, err);
         check_value("timer_irq TCR", wd, rd);
         apb_read(ncpu_irq_pkg::msr_irr, rd, err);
         check_value("timer_irq IRR", 32'd1, rd);
         check_value("timer_irq intr", {31'b0, ~model_imr[0]}, {31'b0, intr});
         wd[ncpu_irq_pkg::tcr_en_bit] = 1'b0;
         wd[ncpu_irq_pkg::tcr_p_bit]  = 1'b0;
         apb_write(ncpu_irq_pkg::msr_tcr, wd, err);
         t1    = acc_cycle;
         tries = 0;
         rd    = 32'd1;
         while (rd[0] && tries < 4)
         begin
            apb_read(ncpu_irq_pkg::msr_irr, rd, err);
            tries++;
         end
         assert (rd[0] == 1'b0 && acc_cycle - t1 <= 5)
         else
         begin
            $display("timer_irq: IRR bit 0 still set 5 cycles after P was cleared");
            test_errs++;
         end
      end
      end_test("timer_irq");

      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// File: vlog.f
ncpu_irq_pkg.sv
msr_apb_slave.sv
ncpu_tsc.sv
ncpu_irqc.sv
ncpu_irq_top.sv
tb_ncpu_irq.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the timer and interrupt testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f vlog.f --top-module tb_ncpu_irq \
   --Mdir obj_dir -o tb_ncpu_irq
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_ncpu_irq)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
